// File: common/rvCtrlPkg.sv
// Control and trace types of the single-cycle core; aluOp encodings are internal, not ISA values
package rvCtrlPkg;

    // ALU operations, PASSB forwards operand B untouched for LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } aluOpE;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wbSrcE;

    // Immediate format picked by decode
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } immSrcE;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;
        logic  aluSrcPc;
        aluOpE aluOp;
        wbSrcE wbSrc;
        logic  branch;
        logic  jump;
        logic  jumpReg;
        logic  illegal;
    } ctrlT;

    // One retired instruction as seen at the end of its cycle
    typedef struct packed {
        logic [31:0] pc;
        logic        rdWrite;
        logic [4:0]  rd;
        logic [31:0] rdData;
        logic        illegal;
    } retireT;

endpackage

// File: common/rvIsaPkg.sv
// RV32I base encodings only; compressed, FENCE and SYSTEM opcodes are not described here
package rvIsaPkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Branch compare kinds
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU group for OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // One view per format, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    // Branch offset bits are scrambled across the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    // Same 32 bits, read through whichever format the opcode implies
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        uTypeT uType;
        jTypeT jType;
    } instrU;

endpackage

// File: decode/decode.sv
// Purely combinational; only word LW/SW are decoded, funct3 of loads and stores is not checked
module decode
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  logic [31:0] instr,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic [31:0] imm,
    output ctrlT        ctrl
);

    instrU  word;
    immSrcE immSrc;

    // ALU op from funct3, alt picks SUB or SRA
    function automatic aluOpE aluOpFor(input logic [2:0] funct3, input logic alt);
        aluOpE op;
        case (funct3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SRL:  op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign word = instr;

    // Register fields sit at the same place in every format
    assign rs1 = word.rType.rs1;
    assign rs2 = word.rType.rs2;
    assign rd  = word.rType.rd;

    // Sign-extended immediate, B and J offsets are even
    always_comb
    begin
        case (immSrc)
            IMM_I:   imm = {{20{word.iType.imm[11]}}, word.iType.imm};
            IMM_S:   imm = {{20{word.sType.immHi[6]}}, word.sType.immHi, word.sType.immLo};
            IMM_B:   imm = {{19{word.bType.imm12}}, word.bType.imm12, word.bType.imm11,
                            word.bType.imm10to5, word.bType.imm4to1, 1'b0};
            IMM_U:   imm = {word.uType.imm, 12'b0};
            IMM_J:   imm = {{11{word.jType.imm20}}, word.jType.imm20, word.jType.imm19to12,
                            word.jType.imm11, word.jType.imm10to1, 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb
    begin
        // Quiet defaults, every strobe low
        ctrl       = '0;
        ctrl.aluOp = ALU_ADD;
        ctrl.wbSrc = WB_ALU;
        immSrc     = IMM_I;
        case (word.rType.opcode)
            OPC_LUI:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = ALU_PASSB;
                immSrc         = IMM_U;
            end
            OPC_AUIPC:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSrcPc  = 1'b1;
                immSrc         = IMM_U;
            end
            OPC_JAL:
            begin
                // Target comes from the PC adder, ALU idles
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.wbSrc    = WB_PC4;
                immSrc        = IMM_J;
            end
            OPC_JALR:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.jumpReg   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSrc     = WB_PC4;
            end
            OPC_BRANCH:
            begin
                ctrl.branch = 1'b1;
                immSrc      = IMM_B;
            end
            OPC_LOAD:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSrc     = WB_MEM;
            end
            OPC_STORE:
            begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                immSrc         = IMM_S;
            end
            OPC_OPIMM:
            begin
                // No SUBI, funct7 bit only marks SRAI
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluOpFor(word.iType.funct3,
                    (word.iType.funct3 == F3_SRL) && word.rType.funct7[5]);
            end
            OPC_OP:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluOpFor(word.rType.funct3, word.rType.funct7[5]);
            end
            default:
            begin
                // Retires as a no-op
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: run.sh
#!/bin/sh
# Verilator build and run of rvCoreTb, the log decides the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module rvCoreTb \
    -Mdir obj_dir -o rvCoreSim \
    && ./obj_dir/rvCoreSim > sim.log 2>&1
grep -qsx '>>> PASS' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: sim.f
common/rvIsaPkg.sv
common/rvCtrlPkg.sv
decode/decode.sv
verilog/regFile.sv
verilog/alu.sv
verilog/dataMem.sv
verilog/rvCore.sv
test/rvCoreChecker.sv
test/rvCoreTb.sv

// File: test/rvCoreChecker.sv
// Bound into rvCore; checks pc alignment, silent illegal words and retireValid during reset
module rvCoreChecker
    import rvCtrlPkg::*;
(
    input logic        clock,
    input logic        rstN,
    input logic [31:0] pc,
    input logic        retireValid,
    input ctrlT        ctrl
);

    timeunit 1ns;
    timeprecision 1ps;

    // Every fetch address is a whole word
    pcAligned: assert property (@(posedge clock) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc is not word-aligned");

    // An unknown opcode must not touch registers or memory
    illegalQuiet: assert property (@(posedge clock) disable iff (!rstN)
        ctrl.illegal |-> (!ctrl.regWrite && !ctrl.memWrite))
        else $error("write strobe raised for an illegal instruction");

    // Nothing retires while reset is held
    resetQuiet: assert property (@(posedge clock) !rstN |=> !retireValid)
        else $error("retireValid high during reset");

endmodule

bind rvCore rvCoreChecker uChecker (
    .clock       (clock),
    .rstN        (rstN),
    .pc          (pc),
    .retireValid (retireValid),
    .ctrl        (ctrl)
);

// File: test/rvCoreTb.sv
// Random forward-only program checked each cycle against an ISA model; stops at the first error
module rvCoreTb
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          clockPeriod   = 100;
    localparam int          sampleDelay   = 40;
    localparam int          progLen       = 200;
    localparam int          timeoutCycles = progLen + 50;
    localparam int          dmemWords     = 256;
    localparam logic [31:0] resetPc       = 32'h0000_0100;
    localparam logic [31:0] endPc         = resetPc + 32'((progLen - 1) * 4);

    // Kinds of program word
    localparam int K_OP    = 0;
    localparam int K_OPIMM = 1;
    localparam int K_LUI   = 2;
    localparam int K_AUIPC = 3;
    localparam int K_LW    = 4;
    localparam int K_SW    = 5;
    localparam int K_BR    = 6;
    localparam int K_JAL   = 7;
    localparam int K_LINK  = 8;
    localparam int K_JALR  = 9;
    localparam int K_BAD   = 10;

    logic        clock = 1'b0;
    logic        rstN;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        retireValid;
    retireT      retire;

    int          seed;
    int          cycle;
    int          step;
    logic        done;
    int          progKind [progLen];
    logic [31:0] progMem [progLen];
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [dmemWords];
    logic [31:0] modelPc;
    retireT      want;

    rvCore #(
        .resetPc   (resetPc),
        .dmemWords (dmemWords)
    ) UUT (
        .clock       (clock),
        .rstN        (rstN),
        .pc          (pc),
        .instr       (instr),
        .retireValid (retireValid),
        .retire      (retire)
    );

    initial
    begin
        forever #(clockPeriod / 2) clock = ~clock;
    end

    task automatic abortRun();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // Uniform draw in 0 .. n-1
    function automatic int pick(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [2:0] branchF3(input int n);
        case (n)
            0:       return F3_BEQ;
            1:       return F3_BNE;
            2:       return F3_BLT;
            3:       return F3_BGE;
            4:       return F3_BLTU;
            default: return F3_BGEU;
        endcase
    endfunction

    // FENCE, SYSTEM, all-zero and custom-2 are outside the kept set
    function automatic logic [6:0] badOpcode(input int n);
        case (n)
            0:       return 7'b0001111;
            1:       return 7'b1110011;
            2:       return 7'b0000000;
            default: return 7'b1011011;
        endcase
    endfunction

    function automatic int drawKind();
        case (pick(20))
            0, 1, 2, 3, 4: return K_OP;
            5, 6, 7, 8:    return K_OPIMM;
            9:             return K_LUI;
            10:            return K_AUIPC;
            11, 12:        return K_LW;
            13, 14:        return K_SW;
            15, 16:        return K_BR;
            17:            return K_JAL;
            18:            return K_LINK;
            default:       return K_BAD;
        endcase
    endfunction

    // Forward target inside the program that never lands on a JALR whose ADDI was skipped
    function automatic int jumpTarget(input int from);
        int t;
        t = from + 1 + pick(6);
        if (t > progLen - 1)
        begin
            t = progLen - 1;
        end
        if (progKind[t] == K_JALR)
        begin
            t = t - 1;
        end
        return t;
    endfunction

    task automatic buildProgram();
        int          i;
        int          t;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [12:0] bOff;
        logic [20:0] jOff;
        // Lay out kinds first so that ADDI x31 and JALR travel as a pair
        i = 0;
        while (i < progLen - 1)
        begin
            progKind[i] = drawKind();
            if (progKind[i] == K_LINK)
            begin
                if (i + 2 < progLen - 1)
                begin
                    progKind[i + 1] = K_JALR;
                    i = i + 1;
                end
                else
                begin
                    progKind[i] = K_OP;
                end
            end
            i = i + 1;
        end
        progKind[progLen - 1] = K_JAL;
        // x31 holds JALR targets and other writes use x0 .. x30
        for (i = 0; i < progLen - 1; i++)
        begin
            f3  = 3'(pick(8));
            alt = ((f3 == F3_ADD) || (f3 == F3_SRL)) && (pick(2) == 1);
            case (progKind[i])
                K_OP:
                    progMem[i] = {1'b0, alt, 5'b0, 5'(pick(32)), 5'(pick(32)), f3,
                                  5'(pick(31)), OPC_OP};
                K_OPIMM:
                begin
                    imm = 12'(pick(4096));
                    if (f3 == F3_SLL)
                    begin
                        imm[11:5] = 7'b0;
                    end
                    else if (f3 == F3_SRL)
                    begin
                        imm[11:5] = {1'b0, alt, 5'b0};
                    end
                    progMem[i] = {imm, 5'(pick(32)), f3, 5'(pick(31)), OPC_OPIMM};
                end
                K_LUI:
                    progMem[i] = {20'(pick(1 << 20)), 5'(pick(31)), OPC_LUI};
                K_AUIPC:
                    progMem[i] = {20'(pick(1 << 20)), 5'(pick(31)), OPC_AUIPC};
                K_LW:
                    progMem[i] = {12'(pick(32) * 4), 5'd0, 3'b010, 5'(pick(31)), OPC_LOAD};
                K_SW:
                begin
                    imm        = 12'(pick(32) * 4);
                    progMem[i] = {imm[11:5], 5'(pick(32)), 5'd0, 3'b010, imm[4:0], OPC_STORE};
                end
                K_BR:
                begin
                    t          = jumpTarget(i);
                    bOff       = 13'((t - i) * 4);
                    progMem[i] = {bOff[12], bOff[10:5], 5'(pick(32)), 5'(pick(32)),
                                  branchF3(pick(6)), bOff[4:1], bOff[11], OPC_BRANCH};
                end
                K_JAL:
                begin
                    t          = jumpTarget(i);
                    jOff       = 21'((t - i) * 4);
                    progMem[i] = {jOff[20], jOff[10:1], jOff[11], jOff[19:12],
                                  5'(pick(31)), OPC_JAL};
                end
                K_LINK:
                begin
                    // Target is taken past the JALR that follows
                    t          = jumpTarget(i + 1);
                    imm        = 12'(resetPc + 32'(t * 4));
                    progMem[i] = {imm, 5'd0, F3_ADD, 5'd31, OPC_OPIMM};
                end
                K_JALR:
                    // Odd offset exercises the cleared low bit
                    progMem[i] = {12'(pick(2)), 5'd31, 3'b000, 5'(pick(31)), OPC_JALR};
                default:
                    progMem[i] = {25'(pick(1 << 25)), badOpcode(pick(4))};
            endcase
        end
        // Self-loop marks the end
        progMem[progLen - 1] = {25'b0, OPC_JAL};
    endtask

    // Combinational fetch port where an out-of-range address gives an illegal word
    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - resetPc;
        if ($isunknown(addr) || (offset[1:0] != 2'b00) || ((offset >> 2) >= 32'(progLen)))
        begin
            return 32'h0000_0000;
        end
        return progMem[int'(offset >> 2)];
    endfunction

    function automatic int memIndex(input logic [31:0] addr);
        return int'((addr >> 2) & 32'(dmemWords - 1));
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return !($signed(a) < $signed(b));
            F3_BLTU: return a < b;
            F3_BGEU: return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b, input logic alt);
        logic [31:0] r;
        case (f3)
            F3_ADD:  r = alt ? (a - b) : (a + b);
            F3_SLL:  r = a << b[4:0];
            F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  r = a ^ b;
            F3_SRL:
            begin
                if (alt)
                begin
                    r = 32'($signed(a) >>> b[4:0]);
                end
                else
                begin
                    r = a >> b[4:0];
                end
            end
            F3_OR:   r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic resetModel();
        for (int i = 0; i < 32; i++)
        begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < dmemWords; i++)
        begin
            modelMem[i] = '0;
        end
        modelPc = resetPc;
    endtask

    // Executes one word on the model and returns the trace it should retire with
    task automatic stepModel(input logic [31:0] word, output retireT exp);
        instrU       w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] result;
        logic [31:0] nextPc;
        logic        writes;
        w      = word;
        a      = modelRegs[w.rType.rs1];
        b      = modelRegs[w.rType.rs2];
        immI   = 32'($signed(w.iType.imm));
        immS   = 32'($signed({w.sType.immHi, w.sType.immLo}));
        immB   = 32'($signed({w.bType.imm12, w.bType.imm11, w.bType.imm10to5,
                              w.bType.imm4to1, 1'b0}));
        immU   = {w.uType.imm, 12'h000};
        immJ   = 32'($signed({w.jType.imm20, w.jType.imm19to12, w.jType.imm11,
                              w.jType.imm10to1, 1'b0}));
        exp    = '0;
        exp.pc = modelPc;
        nextPc = modelPc + 32'd4;
        result = '0;
        writes = 1'b1;
        case (w.rType.opcode)
            OPC_LUI:   result = immU;
            OPC_AUIPC: result = modelPc + immU;
            OPC_JAL:
            begin
                result = modelPc + 32'd4;
                nextPc = modelPc + immJ;
            end
            OPC_JALR:
            begin
                result = modelPc + 32'd4;
                nextPc = (a + immI) & 32'hffff_fffe;
            end
            OPC_BRANCH:
            begin
                writes = 1'b0;
                if (branchTaken(w.bType.funct3, a, b))
                begin
                    nextPc = modelPc + immB;
                end
            end
            OPC_LOAD:  result = modelMem[memIndex(a + immI)];
            OPC_STORE:
            begin
                writes = 1'b0;
                modelMem[memIndex(a + immS)] = b;
            end
            OPC_OPIMM:
                result = aluModel(w.iType.funct3, a, immI,
                                  (w.iType.funct3 == F3_SRL) && w.rType.funct7[5]);
            OPC_OP:    result = aluModel(w.rType.funct3, a, b, w.rType.funct7[5]);
            default:
            begin
                writes      = 1'b0;
                exp.illegal = 1'b1;
            end
        endcase
        if (writes)
        begin
            exp.rdWrite = 1'b1;
            exp.rd      = w.rType.rd;
            exp.rdData  = (w.rType.rd == 5'd0) ? 32'd0 : result;
            if (w.rType.rd != 5'd0)
            begin
                modelRegs[w.rType.rd] = result;
            end
        end
        modelPc = nextPc;
    endtask

    function automatic string traceText(input retireT r);
        return $sformatf("pc=%h rdWrite=%b rd=%0d rdData=%h illegal=%b",
                         r.pc, r.rdWrite, r.rd, r.rdData, r.illegal);
    endfunction

    task automatic checkRetire(input string name, input retireT exp, input retireT act);
        retireT seen;
        seen = act;
        // rd and rdData carry no meaning without a register write
        if (!exp.rdWrite)
        begin
            seen.rd     = '0;
            seen.rdData = '0;
        end
        if (seen !== exp)
        begin
            $display("mismatch %s expected %s actual %s", name, traceText(exp),
                     traceText(seen));
            abortRun();
        end
    endtask

    task automatic checkPc(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("mismatch %s expected %b actual %b", name, exp, act);
            abortRun();
        end
    endtask

    // Longest run is one pass through the program plus reset slack
    initial
    begin
        #(timeoutCycles * clockPeriod);
        $display("simulation did not finish");
        abortRun();
    end

    initial
    begin
        seed  = 32'hc1b0_3ffc;
        rstN  = 1'b0;
        instr = '0;
        done  = 1'b0;
        step  = 0;
        buildProgram();
        resetModel();
        cycle = 0;
        while (!done)
        begin
            @(negedge clock);
            // Two rising edges see reset low
            rstN  = (cycle >= 1);
            instr = fetchWord(pc);
            // Sample just ahead of the rising edge
            #(sampleDelay);
            if (!rstN)
            begin
                checkFlag("retireValid in reset", 1'b0, retireValid);
            end
            else if (cycle >= 2)
            begin
                checkFlag("retireValid after reset", 1'b1, retireValid);
                checkPc((step == 0) ? "pc after reset" : $sformatf("pc step %0d", step),
                        modelPc, pc);
                done = (modelPc == endPc);
                stepModel(instr, want);
                checkRetire($sformatf("retire step %0d", step), want, retire);
                step++;
            end
            cycle++;
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: verilog/alu.sv
// Combinational; take is raw compare result and must be gated by the branch flag outside
module alu
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  aluOpE       op,
    input  logic [2:0]  funct3,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        take
);

    logic [4:0] shamt;

    // RV32 shifts use five bits only
    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_SLL:   result = a << shamt;
            ALU_SLT:   result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:  result = {31'b0, a < b};
            ALU_XOR:   result = a ^ b;
            ALU_SRL:   result = a >> shamt;
            ALU_SRA:   result = $unsigned($signed(a) >>> shamt);
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

    // Branch compare on the register operands
    always_comb
    begin
        case (funct3)
            F3_BEQ:  take = (a == b);
            F3_BNE:  take = (a != b);
            F3_BLT:  take = ($signed(a) < $signed(b));
            F3_BGE:  take = ($signed(a) >= $signed(b));
            F3_BLTU: take = (a < b);
            F3_BGEU: take = (a >= b);
            // funct3 010 and 011 are reserved, never taken
            default: take = 1'b0;
        endcase
    end

endmodule

// File: verilog/dataMem.sv
// Word access only; address bits 1:0 ignored, dmemWords must be a power of two, wraps at depth
module dataMem #(
    parameter int dmemWords = 256
) (
    input  logic        clock,
    input  logic [31:0] addr,
    input  logic        writeEn,
    input  logic [31:0] writeData,
    output logic [31:0] readData
);

    localparam int addrBits = $clog2(dmemWords);

    logic [31:0]         mem [dmemWords];
    logic [addrBits-1:0] index;

    // Word index, upper bits fall away so the space wraps
    assign index = addr[addrBits+1:2];

    // Start from a zeroed memory
    initial
    begin
        for (int i = 0; i < dmemWords; i++)
        begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clock)
    begin
        if (writeEn)
        begin
            mem[index] <= writeData;
        end
    end

    assign readData = mem[index];

endmodule

// File: verilog/regFile.sv
// Synchronous active-low reset clears all 32 registers; writes to x0 are dropped
module regFile (
    input  logic        clock,
    input  logic        rstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        writeEn,
    input  logic [31:0] writeData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [32];

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEn && (rd != 5'd0))
        begin
            regs[rd] <= writeData;
        end
    end

    // Combinational reads, no bypass of the write in flight
    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: verilog/rvCore.sv
// Single-cycle RV32I subset; resetPc must be word-aligned, fetch port is combinational
module rvCore
    import rvCtrlPkg::*;
#(
    parameter logic [31:0] resetPc   = 32'h0000_0000,
    parameter int          dmemWords = 256
) (
    input  logic        clock,
    input  logic        rstN,
    output logic [31:0] pc,
    input  logic [31:0] instr,
    output logic        retireValid,
    output retireT      retire
);

    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    ctrlT        ctrl;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic        take;
    logic [31:0] memData;
    logic [31:0] loadData;
    logic [31:0] pcPlus4;
    logic [31:0] nextPc;
    logic [31:0] wbData;

    decode uDecode (
        .instr (instr),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm),
        .ctrl  (ctrl)
    );

    // Nothing commits until the cycle after reset is released
    regFile uRegFile (
        .clock     (clock),
        .rstN      (rstN),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .writeEn   (ctrl.regWrite && retireValid),
        .writeData (wbData),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    // Operand muxes
    assign aluA = ctrl.aluSrcPc ? pc : rs1Data;
    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    alu uAlu (
        .op     (ctrl.aluOp),
        .funct3 (instr[14:12]),
        .a      (aluA),
        .b      (aluB),
        .result (aluResult),
        .take   (take)
    );

    dataMem #(
        .dmemWords (dmemWords)
    ) uDataMem (
        .clock     (clock),
        .addr      (aluResult),
        .writeEn   (ctrl.memWrite && retireValid),
        .writeData (rs2Data),
        .readData  (memData)
    );

    assign loadData = ctrl.memRead ? memData : '0;
    assign pcPlus4  = pc + 32'd4;

    always_comb
    begin
        case (ctrl.wbSrc)
            WB_MEM:  wbData = loadData;
            WB_PC4:  wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    // JAL and taken branches share the pc-relative adder
    always_comb
    begin
        if (ctrl.jump || (ctrl.branch && take))
        begin
            nextPc = pc + imm;
        end
        else if (ctrl.jumpReg)
        begin
            nextPc = {aluResult[31:1], 1'b0};
        end
        else
        begin
            nextPc = pcPlus4;
        end
    end

    // First cycle after reset holds resetPc with retireValid high
    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            pc          <= resetPc;
            retireValid <= 1'b0;
        end
        else
        begin
            retireValid <= 1'b1;
            if (retireValid)
            begin
                pc <= nextPc;
            end
        end
    end

    // Trace of the instruction at pc, x0 target reports zero
    assign retire.pc      = pc;
    assign retire.rdWrite = ctrl.regWrite;
    assign retire.rd      = rd;
    assign retire.rdData  = (rd == 5'd0) ? '0 : wbData;
    assign retire.illegal = ctrl.illegal;

endmodule
